/* all.f */
hdl/ss_pkg.sv
hdl/singleport_ram.sv
hdl/m68k_ram.sv
hdl/ram_ss_adaptor.sv
hdl/m68k_ram_ss_adaptor.sv
hdl/ss_config.sv
hdl/ss_sequencer.sv
hdl/ss_ram_top.sv
+incdir+bench
bench/tb_ss_ram_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile the save-state RAM testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ss_ram_top -f all.f -o sim_tb

# The simulator exits non-zero on $fatal, so the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, see sim.log"
exit 1

/* bench/tb_ss_model.svh */
// Reference model of the CPU work RAM and the sprite RAM
// Fill patterns, byte-lane merging and typed compare tasks
`ifndef TB_SS_MODEL_SVH
`define TB_SS_MODEL_SVH

logic [15:0]          cpu_model [2**CPU_RAM_AW];
logic [SPR_RAM_W-1:0] spr_model [2**SPR_RAM_AW];

// Both bytes of the fill change with every address bit
function automatic logic [15:0] cpu_fill(input logic [CPU_RAM_AW-1:0] a);
    return 16'({a, ~a}) ^ 16'h3c5a;
endfunction

function automatic logic [SPR_RAM_W-1:0] spr_fill(input logic [SPR_RAM_AW-1:0] a);
    return SPR_RAM_W'({a, ^a}) ^ SPR_RAM_W'(8'h96);
endfunction

// A low strobe replaces its byte lane, a high one keeps the old byte
function automatic logic [15:0] merge_lanes(input logic [15:0] old, input logic [15:0] d,
                                            input logic lds_n, input logic uds_n);
    logic [15:0] merged;
    merged = old;
    if (!lds_n) begin
        merged[7:0] = d[7:0];
    end
    if (!uds_n) begin
        merged[15:8] = d[15:8];
    end
    return merged;
endfunction

// ========================================
// Compare tasks
// ========================================
task automatic check_cpu_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
    if (got !== exp) begin
        report_failure($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
endtask

task automatic check_spr_word(input string name, input logic [SPR_RAM_W-1:0] got,
                              input logic [SPR_RAM_W-1:0] exp);
    if (got !== exp) begin
        report_failure($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
endtask

task automatic check_bus_word(input string name, input logic [SS_DATA_W-1:0] got,
                              input logic [SS_DATA_W-1:0] exp);
    if (got !== exp) begin
        report_failure($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
endtask

`endif

/* bench/tb_ss_ram_top.sv */
// Testbench for the save-state RAM subsystem
// Random traffic on both RAM ports, then save and restore runs checked
// against a reference model of the two RAMs
`timescale 1ns/10ps
`default_nettype none

module tb_ss_ram_top;

    import ss_pkg::*;

    localparam logic [31:0] SEED = 32'hf419_3660;
    localparam int N_CPU_OPS    = 400;
    localparam int N_SPR_OPS    = 300;
    localparam int ALL_WORDS    = 2**CPU_RAM_AW + 2**SPR_RAM_AW;
    localparam int OP_WORDS     = 3 * ALL_WORDS + 2**SPR_RAM_AW;
    localparam int CYC_PER_WORD = 24;
    localparam int TRAFFIC_CYC  = 2 * (N_CPU_OPS + N_SPR_OPS + 2 * ALL_WORDS);
    localparam int MAX_CYCLES   = 2 * (OP_WORDS * CYC_PER_WORD + TRAFFIC_CYC);

    logic                  clk;
    logic                  reset;
    logic                  cpu_lds_n;
    logic                  cpu_uds_n;
    logic [CPU_RAM_AW-1:0] cpu_addr;
    logic [15:0]           cpu_data;
    logic [15:0]           cpu_q;
    logic                  spr_wren;
    logic [SPR_RAM_AW-1:0] spr_addr;
    logic [SPR_RAM_W-1:0]  spr_data;
    logic [SPR_RAM_W-1:0]  spr_q;
    logic                  cfg_write;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    logic [SS_DATA_W-1:0]  cfg_wdata;
    logic [SS_DATA_W-1:0]  cfg_rdata;
    logic                  dump_strobe;
    logic [SS_DATA_W-1:0]  dump_data;
    logic                  load_req;
    logic                  load_strobe;
    logic [SS_DATA_W-1:0]  load_data;
    int                    cycles = 0;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    `include "tb_ss_model.svh"

    ss_ram_top dut0 (
        .clk(clk), .reset(reset),
        .cpu_lds_n(cpu_lds_n), .cpu_uds_n(cpu_uds_n), .cpu_addr(cpu_addr),
        .cpu_data(cpu_data), .cpu_q(cpu_q),
        .spr_wren(spr_wren), .spr_addr(spr_addr), .spr_data(spr_data), .spr_q(spr_q),
        .cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
        .dump_strobe(dump_strobe), .dump_data(dump_data),
        .load_req(load_req), .load_strobe(load_strobe), .load_data(load_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            report_failure($sformatf("Timeout: the run passed %0d cycles unfinished", cycles));
        end
    end

    // ========================================
    // Port access tasks
    // ========================================
    task automatic cpu_access(input logic [CPU_RAM_AW-1:0] a, input logic [15:0] d,
                              input logic lds_n, input logic uds_n);
        @(negedge clk);
        cpu_addr  = a;
        cpu_data  = d;
        cpu_lds_n = lds_n;
        cpu_uds_n = uds_n;
        cpu_model[a] = merge_lanes(cpu_model[a], d, lds_n, uds_n);
        @(negedge clk);
        check_cpu_word("cpu_q", cpu_q, cpu_model[a]);
        cpu_lds_n = 1'b1;
        cpu_uds_n = 1'b1;
    endtask

    task automatic spr_access(input logic [SPR_RAM_AW-1:0] a, input logic [SPR_RAM_W-1:0] d,
                              input logic wr);
        @(negedge clk);
        spr_addr = a;
        spr_data = d;
        spr_wren = wr;
        if (wr) begin
            spr_model[a] = d;
        end
        @(negedge clk);
        check_spr_word("spr_q", spr_q, spr_model[a]);
        spr_wren = 1'b0;
    endtask

    task automatic write_reg(input logic [CFG_ADDR_W-1:0] a, input logic [SS_DATA_W-1:0] d);
        @(negedge clk);
        cfg_write = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        @(negedge clk);
        cfg_write = 1'b0;
        cfg_addr  = CFG_STAT;
    endtask

    // ========================================
    // Save or restore run
    // ========================================
    // Entries below 2**CPU_RAM_AW are CPU words, the rest sprite words.
    // With poke set, a CTRL write lands in the middle of the run.
    task automatic run_op(input logic do_restore, input logic [1:0] mask, input logic poke);
        int                   addr_q[$];
        int                   entry;
        int                   delay;
        int                   iter;
        int                   n_words;
        logic                 answer_due;
        logic                 ctrl_shown;
        logic                 busy_seen;
        logic [SS_DATA_W-1:0] word;
        for (int a = 0; mask[SS_IDX_CPU] && a < 2**CPU_RAM_AW; a++) begin
            addr_q.push_back(a);
        end
        for (int a = 0; mask[SS_IDX_SPR] && a < 2**SPR_RAM_AW; a++) begin
            addr_q.push_back(2**CPU_RAM_AW + a);
        end
        n_words    = addr_q.size();
        answer_due = 1'b0;
        ctrl_shown = 1'b0;
        busy_seen  = 1'b1;
        delay      = 0;
        iter       = 0;
        write_reg(CFG_MASK, SS_DATA_W'(mask));
        write_reg(CFG_CTRL, SS_DATA_W'({do_restore, 1'b1}));
        #1;
        if (!cfg_rdata[0]) begin
            report_failure("busy did not rise one cycle after the go write");
        end
        while (busy_seen) begin
            @(negedge clk);
            iter++;
            load_strobe = 1'b0;
            if (dump_strobe) begin
                if (do_restore || addr_q.size() == 0) begin
                    report_failure("dump_strobe pulsed with no word due");
                end
                entry = addr_q.pop_front();
                if (entry < 2**CPU_RAM_AW) begin
                    check_cpu_word("dump_data", dump_data, cpu_model[entry]);
                end else begin
                    check_bus_word("dump_data", dump_data,
                                   SS_DATA_W'(spr_model[entry - 2**CPU_RAM_AW]));
                end
            end
            if (load_req) begin
                if (!do_restore || answer_due || addr_q.size() == 0) begin
                    report_failure("load_req pulsed with no word due");
                end
                answer_due = 1'b1;
                delay      = $urandom_range(3, 0);
            end
            if (answer_due && delay == 0) begin
                entry       = addr_q.pop_front();
                word        = SS_DATA_W'($urandom);
                load_strobe = 1'b1;
                load_data   = word;
                answer_due  = 1'b0;
                if (entry < 2**CPU_RAM_AW) begin
                    cpu_model[entry] = word;
                end else begin
                    spr_model[entry - 2**CPU_RAM_AW] = word[SPR_RAM_W-1:0];
                end
            end else if (answer_due) begin
                delay--;
            end
            if (ctrl_shown) begin
                // The blocked write must leave the restore bit as it was
                check_bus_word("cfg_rdata", cfg_rdata, SS_DATA_W'({do_restore, 1'b0}));
                cfg_write  = 1'b0;
                cfg_addr   = CFG_STAT;
                ctrl_shown = 1'b0;
            end else begin
                busy_seen = cfg_rdata[0];
                if (busy_seen && poke && iter == 40) begin
                    cfg_write  = 1'b1;
                    cfg_addr   = CFG_CTRL;
                    cfg_wdata  = SS_DATA_W'({!do_restore, 1'b1});
                    ctrl_shown = 1'b1;
                end
            end
        end
        if (addr_q.size() != 0 || answer_due) begin
            report_failure($sformatf("busy fell with %0d words not moved", addr_q.size()));
        end
        // The sticky done flag lands one cycle after busy falls
        @(negedge clk);
        check_bus_word("cfg_rdata", cfg_rdata, SS_DATA_W'({WORD_CNT_W'(n_words), 2'b10}));
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int                    kind;
        logic [CPU_RAM_AW-1:0] ca;
        logic [SPR_RAM_AW-1:0] sa;
        logic [15:0]           cd;
        void'($urandom(SEED));
        reset       = 1'b1;
        cpu_lds_n   = 1'b1;
        cpu_uds_n   = 1'b1;
        cpu_addr    = '0;
        cpu_data    = '0;
        spr_wren    = 1'b0;
        spr_addr    = '0;
        spr_data    = '0;
        cfg_write   = 1'b0;
        cfg_addr    = CFG_STAT;
        cfg_wdata   = '0;
        load_strobe = 1'b0;
        load_data   = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        if (dump_strobe || load_req) begin
            report_failure("dump_strobe or load_req high after reset");
        end
        check_bus_word("cfg_rdata", cfg_rdata, '0);

        for (int i = 0; i < 2**CPU_RAM_AW; i++) begin
            cpu_access(CPU_RAM_AW'(i), cpu_fill(CPU_RAM_AW'(i)), 1'b0, 1'b0);
        end
        for (int i = 0; i < 2**SPR_RAM_AW; i++) begin
            spr_access(SPR_RAM_AW'(i), spr_fill(SPR_RAM_AW'(i)), 1'b1);
        end

        // Random reads, word writes and single-byte writes
        repeat (N_CPU_OPS) begin
            kind = $urandom_range(3, 0);
            ca   = CPU_RAM_AW'($urandom);
            cd   = 16'($urandom);
            case (kind)
                0:       cpu_access(ca, cd, 1'b1, 1'b1);
                1:       cpu_access(ca, cd, 1'b0, 1'b0);
                2:       cpu_access(ca, cd, 1'b0, 1'b1);
                default: cpu_access(ca, cd, 1'b1, 1'b0);
            endcase
        end
        repeat (N_SPR_OPS) begin
            sa = SPR_RAM_AW'($urandom);
            spr_access(sa, SPR_RAM_W'($urandom), 1'($urandom));
        end

        run_op(1'b0, 2'b11, 1'b0);
        run_op(1'b0, 2'b10, 1'b0);
        run_op(1'b0, 2'b00, 1'b0);

        run_op(1'b1, 2'b11, 1'b0);
        for (int i = 0; i < 2**CPU_RAM_AW; i++) begin
            cpu_access(CPU_RAM_AW'(i), 16'h0000, 1'b1, 1'b1);
        end
        for (int i = 0; i < 2**SPR_RAM_AW; i++) begin
            spr_access(SPR_RAM_AW'(i), '0, 1'b0);
        end

        run_op(1'b0, 2'b11, 1'b1);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/ss_ram_top.sv */
// Save-state RAM subsystem
// CPU work RAM and sprite RAM behind save-state adaptors, driven by the
// sequencer and its host register block
`timescale 1ns/10ps
`default_nettype none

module ss_ram_top (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              cpu_lds_n,
    input  wire                              cpu_uds_n,
    input  wire  [ss_pkg::CPU_RAM_AW-1:0]    cpu_addr,
    input  wire  [15:0]                      cpu_data,
    output logic [15:0]                      cpu_q,
    input  wire                              spr_wren,
    input  wire  [ss_pkg::SPR_RAM_AW-1:0]    spr_addr,
    input  wire  [ss_pkg::SPR_RAM_W-1:0]     spr_data,
    output logic [ss_pkg::SPR_RAM_W-1:0]     spr_q,
    input  wire                              cfg_write,
    input  wire  [ss_pkg::CFG_ADDR_W-1:0]    cfg_addr,
    input  wire  [ss_pkg::SS_DATA_W-1:0]     cfg_wdata,
    output logic [ss_pkg::SS_DATA_W-1:0]     cfg_rdata,
    output logic                             dump_strobe,
    output logic [ss_pkg::SS_DATA_W-1:0]     dump_data,
    output logic                             load_req,
    input  wire                              load_strobe,
    input  wire  [ss_pkg::SS_DATA_W-1:0]     load_data
);

    import ss_pkg::*;

    // Save-state bus
    logic [SS_IDX_W-1:0]  ss_sel;
    logic [SS_ADDR_W-1:0] ss_addr;
    logic [SS_DATA_W-1:0] ss_wdata, ss_rdata, cpu_ss_rdata, spr_ss_rdata;
    logic                 ss_write, ss_read, ss_ack, cpu_ss_ack, spr_ss_ack;

    // RAM-side ports after the adaptors
    logic                  cpu_ram_lds_n, cpu_ram_uds_n, spr_ram_wren;
    logic [CPU_RAM_AW-1:0] cpu_ram_addr;
    logic [15:0]           cpu_ram_data;
    logic [SPR_RAM_AW-1:0] spr_ram_addr;
    logic [SPR_RAM_W-1:0]  spr_ram_data;

    // Sequencer control
    logic                      go, restore, busy, done;
    logic [SS_NUM_REGIONS-1:0] region_mask;
    logic [WORD_CNT_W-1:0]     word_count;

    // Idle adaptors drive zero, so a plain OR merges the responses
    assign ss_ack   = cpu_ss_ack | spr_ss_ack;
    assign ss_rdata = cpu_ss_rdata | spr_ss_rdata;

    // ========================================
    // CPU work RAM
    // ========================================
    m68k_ram_ss_adaptor #(.WIDTHAD(CPU_RAM_AW), .SS_IDX(SS_IDX_CPU)) cpu_adaptor0 (
        .clk(clk), .reset(reset),
        .lds_n_in(cpu_lds_n), .uds_n_in(cpu_uds_n), .addr_in(cpu_addr), .data_in(cpu_data),
        .lds_n_out(cpu_ram_lds_n), .uds_n_out(cpu_ram_uds_n),
        .addr_out(cpu_ram_addr), .data_out(cpu_ram_data), .q(cpu_q),
        .ss_sel(ss_sel), .ss_addr(ss_addr), .ss_wdata(ss_wdata),
        .ss_write(ss_write), .ss_read(ss_read), .ss_ack(cpu_ss_ack), .ss_rdata(cpu_ss_rdata)
    );

    m68k_ram #(.WIDTHAD(CPU_RAM_AW)) cpu_ram0 (
        .clk(clk), .we_lds_n(cpu_ram_lds_n), .we_uds_n(cpu_ram_uds_n),
        .address(cpu_ram_addr), .data(cpu_ram_data), .q(cpu_q)
    );

    // ========================================
    // Sprite RAM
    // ========================================
    ram_ss_adaptor #(.WIDTH(SPR_RAM_W), .WIDTHAD(SPR_RAM_AW), .SS_IDX(SS_IDX_SPR)) spr_adaptor0 (
        .clk(clk), .reset(reset),
        .wren_in(spr_wren), .addr_in(spr_addr), .data_in(spr_data),
        .wren_out(spr_ram_wren), .addr_out(spr_ram_addr), .data_out(spr_ram_data), .q(spr_q),
        .ss_sel(ss_sel), .ss_addr(ss_addr), .ss_wdata(ss_wdata),
        .ss_write(ss_write), .ss_read(ss_read), .ss_ack(spr_ss_ack), .ss_rdata(spr_ss_rdata)
    );

    singleport_ram #(.WIDTH(SPR_RAM_W), .WIDTHAD(SPR_RAM_AW)) spr_ram0 (
        .clk(clk), .wren(spr_ram_wren), .address(spr_ram_addr), .data(spr_ram_data), .q(spr_q)
    );

    // ========================================
    // Sequencer and registers
    // ========================================
    ss_config config0 (
        .clk(clk), .reset(reset),
        .cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
        .go(go), .restore(restore), .region_mask(region_mask),
        .busy(busy), .done(done), .word_count(word_count)
    );

    ss_sequencer sequencer0 (
        .clk(clk), .reset(reset), .go(go), .restore(restore), .region_mask(region_mask),
        .ss_sel(ss_sel), .ss_addr(ss_addr), .ss_wdata(ss_wdata),
        .ss_write(ss_write), .ss_read(ss_read), .ss_ack(ss_ack), .ss_rdata(ss_rdata),
        .dump_strobe(dump_strobe), .dump_data(dump_data),
        .load_req(load_req), .load_strobe(load_strobe), .load_data(load_data),
        .busy(busy), .done(done), .word_count(word_count)
    );

endmodule

`default_nettype wire

/* hdl/ss_sequencer.sv */
// Save-state sequencer
// Walks each enabled region word by word, dumping words out in save mode
// and writing host-supplied words back in restore mode
`timescale 1ns/10ps
`default_nettype none

module ss_sequencer (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                go,
    input  wire                                restore,
    input  wire  [ss_pkg::SS_NUM_REGIONS-1:0]  region_mask,
    output logic [ss_pkg::SS_IDX_W-1:0]        ss_sel,
    output logic [ss_pkg::SS_ADDR_W-1:0]       ss_addr,
    output logic [ss_pkg::SS_DATA_W-1:0]       ss_wdata,
    output logic                               ss_write,
    output logic                               ss_read,
    input  wire                                ss_ack,
    input  wire  [ss_pkg::SS_DATA_W-1:0]       ss_rdata,
    output logic                               dump_strobe,
    output logic [ss_pkg::SS_DATA_W-1:0]       dump_data,
    output logic                               load_req,
    input  wire                                load_strobe,
    input  wire  [ss_pkg::SS_DATA_W-1:0]       load_data,
    output logic                               busy,
    output logic                               done,
    output logic [ss_pkg::WORD_CNT_W-1:0]      word_count
);

    import ss_pkg::*;

    logic [SEQ_STATE_W-1:0]    state;
    logic                      mode_restore;
    logic [SS_NUM_REGIONS-1:0] pending;
    logic [SS_ADDR_W-1:0]      last_addr;

    // Region lengths come straight from the RAM geometry
    assign last_addr = (ss_sel == SS_IDX_CPU) ? SS_ADDR_W'(2**CPU_RAM_AW - 1)
                                              : SS_ADDR_W'(2**SPR_RAM_AW - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= SEQ_IDLE;
            mode_restore <= 1'b0;
            pending      <= '0;
            ss_sel       <= '0;
            ss_read      <= 1'b0;
            ss_write     <= 1'b0;
            dump_strobe  <= 1'b0;
            load_req     <= 1'b0;
            busy         <= 1'b0;
            done         <= 1'b0;
            word_count   <= '0;
        end else begin
            dump_strobe <= 1'b0;
            load_req    <= 1'b0;
            done        <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (go) begin
                        mode_restore <= restore;
                        pending      <= region_mask;
                        ss_sel       <= '0;
                        word_count   <= '0;
                        busy         <= 1'b1;
                        state        <= SEQ_FIND;
                    end
                end
                // Regions are retired from pending as they finish
                SEQ_FIND: begin
                    ss_addr <= '0;
                    if (pending == '0) begin
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= SEQ_IDLE;
                    end else if (pending[ss_sel]) begin
                        state <= SEQ_START;
                    end else begin
                        ss_sel <= ss_sel + 1'b1;
                    end
                end
                SEQ_START: begin
                    if (mode_restore) begin
                        load_req <= 1'b1;
                        state    <= SEQ_LOAD;
                    end else begin
                        ss_read <= 1'b1;
                        state   <= SEQ_XFER;
                    end
                end
                SEQ_LOAD: begin
                    if (load_strobe) begin
                        ss_wdata <= load_data;
                        ss_write <= 1'b1;
                        state    <= SEQ_XFER;
                    end
                end
                // Hold the access until the adaptor acks, then drop it
                SEQ_XFER: begin
                    if (ss_ack) begin
                        ss_read     <= 1'b0;
                        ss_write    <= 1'b0;
                        dump_strobe <= !mode_restore;
                        dump_data   <= ss_rdata;
                        word_count  <= word_count + 1'b1;
                        state       <= SEQ_NEXT;
                    end
                end
                SEQ_NEXT: begin
                    if (ss_addr == last_addr) begin
                        pending[ss_sel] <= 1'b0;
                        state           <= SEQ_FIND;
                    end else begin
                        ss_addr <= ss_addr + 1'b1;
                        state   <= SEQ_START;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(ss_read && ss_write))
        else $error("Save-state read and write raised together");

    assert property (@(posedge clk) disable iff (reset) load_strobe |-> state != SEQ_IDLE)
        else $error("Load strobe arrived with no operation running");

endmodule

`default_nettype wire

/* hdl/ss_config.sv */
// Save-state host register block
// CTRL starts a save or restore, MASK picks the regions, STAT reports progress
`timescale 1ns/10ps
`default_nettype none

module ss_config (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                cfg_write,
    input  wire  [ss_pkg::CFG_ADDR_W-1:0]      cfg_addr,
    input  wire  [ss_pkg::SS_DATA_W-1:0]       cfg_wdata,
    output logic [ss_pkg::SS_DATA_W-1:0]       cfg_rdata,
    output logic                               go,
    output logic                               restore,
    output logic [ss_pkg::SS_NUM_REGIONS-1:0]  region_mask,
    input  wire                                busy,
    input  wire                                done,
    input  wire  [ss_pkg::WORD_CNT_W-1:0]      word_count
);

    import ss_pkg::*;

    logic ctrl_wr;
    logic restore_r;
    logic done_r;

    // CTRL is locked while an operation runs
    assign ctrl_wr = cfg_write && (cfg_addr == CFG_CTRL) && !busy;

    // Go is never stored, so it lasts exactly the cycle of the write
    assign go      = ctrl_wr && cfg_wdata[0];
    assign restore = ctrl_wr ? cfg_wdata[1] : restore_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            restore_r   <= 1'b0;
            region_mask <= '0;
            done_r      <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                restore_r <= cfg_wdata[1];
            end
            if (cfg_write && (cfg_addr == CFG_MASK)) begin
                region_mask <= cfg_wdata[SS_NUM_REGIONS-1:0];
            end
            // Sticky until the next operation starts
            if (done) begin
                done_r <= 1'b1;
            end else if (go) begin
                done_r <= 1'b0;
            end
        end
    end

    // ========================================
    // Read-back
    // ========================================
    always_comb begin
        case (cfg_addr)
            CFG_CTRL: cfg_rdata = {{(SS_DATA_W-2){1'b0}}, restore_r, 1'b0};
            CFG_MASK: cfg_rdata = SS_DATA_W'(region_mask);
            CFG_STAT: cfg_rdata = {word_count, done_r, busy};
            default:  cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/m68k_ram_ss_adaptor.sv */
// Save-state adaptor for the byte-lane CPU RAM
// Same takeover as the generic adaptor; save-state writes hit both lanes
`timescale 1ns/10ps
`default_nettype none

module m68k_ram_ss_adaptor #(
    parameter int                          WIDTHAD = 10,
    parameter logic [ss_pkg::SS_IDX_W-1:0] SS_IDX  = '0
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            lds_n_in,
    input  wire                            uds_n_in,
    input  wire  [WIDTHAD-1:0]             addr_in,
    input  wire  [15:0]                    data_in,
    output logic                           lds_n_out,
    output logic                           uds_n_out,
    output logic [WIDTHAD-1:0]             addr_out,
    output logic [15:0]                    data_out,
    input  wire  [15:0]                    q,
    input  wire  [ss_pkg::SS_IDX_W-1:0]    ss_sel,
    input  wire  [ss_pkg::SS_ADDR_W-1:0]   ss_addr,
    input  wire  [ss_pkg::SS_DATA_W-1:0]   ss_wdata,
    input  wire                            ss_write,
    input  wire                            ss_read,
    output logic                           ss_ack,
    output logic [ss_pkg::SS_DATA_W-1:0]   ss_rdata
);

    import ss_pkg::*;

    logic accessed;
    logic read_delay;

    assign accessed = (ss_sel == SS_IDX) && (ss_read || ss_write);

    assign addr_out  = accessed ? ss_addr[WIDTHAD-1:0] : addr_in;
    assign data_out  = accessed ? ss_wdata[15:0] : data_in;
    // A save-state word always covers both bytes
    assign lds_n_out = accessed ? !ss_write : lds_n_in;
    assign uds_n_out = accessed ? !ss_write : uds_n_in;

    assign ss_rdata = ss_ack ? SS_DATA_W'(q) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            read_delay <= 1'b0;
            ss_ack     <= 1'b0;
        end else begin
            read_delay <= accessed && ss_read;
            ss_ack     <= accessed && !ss_ack && (ss_write || (ss_read && read_delay));
        end
    end

    // The sequencer must keep the access up until it has seen the ack
    assert property (@(posedge clk) disable iff (reset) ss_ack |-> accessed)
        else $error("ss_ack raised with no access to this region");

endmodule

`default_nettype wire

/* hdl/ram_ss_adaptor.sv */
// Save-state adaptor for a single-port RAM
// Passes the owning port through, or hands the RAM to the save-state bus
// when this region is selected
`timescale 1ns/10ps
`default_nettype none

module ram_ss_adaptor #(
    parameter int                          WIDTH   = 8,
    parameter int                          WIDTHAD = 10,
    parameter logic [ss_pkg::SS_IDX_W-1:0] SS_IDX  = '0
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            wren_in,
    input  wire  [WIDTHAD-1:0]             addr_in,
    input  wire  [WIDTH-1:0]               data_in,
    output logic                           wren_out,
    output logic [WIDTHAD-1:0]             addr_out,
    output logic [WIDTH-1:0]               data_out,
    input  wire  [WIDTH-1:0]               q,
    input  wire  [ss_pkg::SS_IDX_W-1:0]    ss_sel,
    input  wire  [ss_pkg::SS_ADDR_W-1:0]   ss_addr,
    input  wire  [ss_pkg::SS_DATA_W-1:0]   ss_wdata,
    input  wire                            ss_write,
    input  wire                            ss_read,
    output logic                           ss_ack,
    output logic [ss_pkg::SS_DATA_W-1:0]   ss_rdata
);

    import ss_pkg::*;

    logic accessed;
    logic read_delay;

    assign accessed = (ss_sel == SS_IDX) && (ss_read || ss_write);

    assign addr_out = accessed ? ss_addr[WIDTHAD-1:0] : addr_in;
    assign data_out = accessed ? ss_wdata[WIDTH-1:0] : data_in;
    assign wren_out = accessed ? ss_write : wren_in;

    // Zero whenever not acking so the top level can OR both adaptors
    assign ss_rdata = ss_ack ? SS_DATA_W'(q) : '0;

    // Writes ack one cycle in, reads wait one more cycle for the RAM output
    always_ff @(posedge clk) begin
        if (reset) begin
            read_delay <= 1'b0;
            ss_ack     <= 1'b0;
        end else begin
            read_delay <= accessed && ss_read;
            ss_ack     <= accessed && !ss_ack && (ss_write || (ss_read && read_delay));
        end
    end

    // The sequencer must keep the access up until it has seen the ack
    assert property (@(posedge clk) disable iff (reset) ss_ack |-> accessed)
        else $error("ss_ack raised with no access to this region");

endmodule

`default_nettype wire

/* hdl/m68k_ram.sv */
// 68000-style work RAM
// 16-bit words held as two byte lanes, each with an active-low write strobe
`timescale 1ns/10ps
`default_nettype none

module m68k_ram #(
    parameter int WIDTHAD = 10
) (
    input  wire                clk,
    input  wire                we_lds_n,
    input  wire                we_uds_n,
    input  wire  [WIDTHAD-1:0] address,
    input  wire  [15:0]        data,
    output logic [15:0]        q
);

    logic [7:0] mem_l [2**WIDTHAD];
    logic [7:0] mem_h [2**WIDTHAD];

    // ========================================
    // Lower byte lane
    // ========================================
    always_ff @(posedge clk) begin
        if (!we_lds_n) begin
            mem_l[address] <= data[7:0];
            q[7:0]         <= data[7:0];
        end else begin
            q[7:0] <= mem_l[address];
        end
    end

    // ========================================
    // Upper byte lane
    // ========================================
    always_ff @(posedge clk) begin
        if (!we_uds_n) begin
            mem_h[address] <= data[15:8];
            q[15:8]        <= data[15:8];
        end else begin
            q[15:8] <= mem_h[address];
        end
    end

endmodule

`default_nettype wire

/* hdl/singleport_ram.sv */
// Single-port RAM model
// Registered read, written data appears on q in the cycle after the write
`timescale 1ns/10ps
`default_nettype none

module singleport_ram #(
    parameter int WIDTH   = 8,
    parameter int WIDTHAD = 10
) (
    input  wire                clk,
    input  wire                wren,
    input  wire  [WIDTHAD-1:0] address,
    input  wire  [WIDTH-1:0]   data,
    output logic [WIDTH-1:0]   q
);

    logic [WIDTH-1:0] mem [2**WIDTHAD];

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[address] <= data;
        end
        // Write-through so a read of the word being written sees new data
        q <= wren ? data : mem[address];
    end

endmodule

`default_nettype wire

/* hdl/ss_pkg.sv */
// Save-state subsystem constants
// Bus widths, RAM geometry, region indices, register map and sequencer states
`default_nettype none

package ss_pkg;

    // ========================================
    // Save-state bus
    // ========================================
    localparam int SS_DATA_W      = 16;
    localparam int SS_ADDR_W      = 8;
    localparam int SS_IDX_W       = 1;
    localparam int SS_NUM_REGIONS = 2 ** SS_IDX_W;

    // Region indices, walked in ascending order
    localparam logic [SS_IDX_W-1:0] SS_IDX_CPU = 1'd0;
    localparam logic [SS_IDX_W-1:0] SS_IDX_SPR = 1'd1;

    // ========================================
    // Work RAM geometry
    // ========================================
    localparam int CPU_RAM_AW = 8;
    localparam int SPR_RAM_AW = 7;
    localparam int SPR_RAM_W  = 8;

    // ========================================
    // Host registers
    // ========================================
    localparam int CFG_ADDR_W = 2;
    localparam logic [CFG_ADDR_W-1:0] CFG_CTRL = 2'd0;
    localparam logic [CFG_ADDR_W-1:0] CFG_MASK = 2'd1;
    localparam logic [CFG_ADDR_W-1:0] CFG_STAT = 2'd2;

    // STAT holds busy and done below the word count
    localparam int WORD_CNT_W = SS_DATA_W - 2;

    // Sequencer FSM encoding
    localparam int SEQ_STATE_W = 3;
    localparam logic [SEQ_STATE_W-1:0] SEQ_IDLE  = 3'd0;
    localparam logic [SEQ_STATE_W-1:0] SEQ_FIND  = 3'd1;
    localparam logic [SEQ_STATE_W-1:0] SEQ_START = 3'd2;
    localparam logic [SEQ_STATE_W-1:0] SEQ_LOAD  = 3'd3;
    localparam logic [SEQ_STATE_W-1:0] SEQ_XFER  = 3'd4;
    localparam logic [SEQ_STATE_W-1:0] SEQ_NEXT  = 3'd5;

endpackage

`default_nettype wire
